/* hw/nn_consts.svh */
`ifndef NN_CONSTS_SVH
`define NN_CONSTS_SVH

//////////////////////////////
// Network sizes
//////////////////////////////

`define NN_FEAT_CNT   12
`define NN_FEAT_BITS  4
`define NN_HIDDEN_CNT 40
`define NN_CLASS_CNT  6

//////////////////////////////
// Derived widths
//////////////////////////////

// A feature sum must hold every lane at its maximum value.
`define NN_SUM_BITS   ($clog2(`NN_FEAT_CNT * ((1 << `NN_FEAT_BITS) - 1) + 1))
`define NN_POP_BITS   ($clog2(`NN_HIDDEN_CNT + 1))
// Two extra bits cover the doubling and the class bias.
`define NN_SCORE_BITS (`NN_POP_BITS + 2)
`define NN_INDEX_BITS ($clog2(`NN_CLASS_CNT))

`endif

/* hw/nn_types_pkg.sv */
`include "nn_consts.svh"

package nn_types_pkg;

    // The same 48 bits are seen as one flat bus at the top level and as
    // twelve lanes in the datapath. Lane 0 is the most significant nibble.
    typedef union packed {
        logic [`NN_FEAT_CNT*`NN_FEAT_BITS-1:0]      flat;
        logic [0:`NN_FEAT_CNT-1][`NN_FEAT_BITS-1:0] lane;
    } feature_word_u;

    // Bit n holds the output of hidden neuron n.
    typedef logic [`NN_HIDDEN_CNT-1:0] hidden_vec_t;

    typedef logic [`NN_SCORE_BITS-1:0] score_t;

    typedef logic [`NN_INDEX_BITS-1:0] class_idx_t;

endpackage

/* hw/nn_weights_pkg.sv */
`include "nn_consts.svh"

package nn_weights_pkg;

    //////////////////////////////
    // Hidden layer
    //////////////////////////////

    // Feature 0 is the leftmost bit of each mask. Entries run from neuron 0 to 39.
    localparam logic [0:`NN_FEAT_CNT-1] hidden_pos_mask [`NN_HIDDEN_CNT] = '{
        12'b0100_0010_1011, 12'b0101_0100_1100, 12'b0000_0000_0000, 12'b0011_0000_0000,
        12'b0001_0011_1000, 12'b0000_0000_0000, 12'b0011_0000_0101, 12'b0110_0010_1001,
        12'b0000_0100_0000, 12'b1100_0100_0101, 12'b0001_0000_1100, 12'b0011_0001_0000,
        12'b0000_1111_0101, 12'b1100_0001_0010, 12'b1010_0011_0010, 12'b0101_0000_0000,
        12'b1001_0000_1000, 12'b1000_0000_1000, 12'b0001_0100_0101, 12'b1000_0110_1011,
        12'b0000_1000_1101, 12'b0000_0011_0000, 12'b0000_0100_0010, 12'b0010_0001_0011,
        12'b0001_0011_0101, 12'b0101_1010_0100, 12'b0010_0010_0010, 12'b0101_0000_0100,
        12'b0000_0101_0000, 12'b1001_1010_0000, 12'b1001_0000_1000, 12'b1101_0000_1000,
        12'b0110_0000_0000, 12'b0100_1011_0000, 12'b0100_1001_0011, 12'b0100_1000_0110,
        12'b0101_0000_0000, 12'b0000_0011_0000, 12'b0000_1000_1000, 12'b1001_0001_0010
    };

    localparam logic [0:`NN_FEAT_CNT-1] hidden_neg_mask [`NN_HIDDEN_CNT] = '{
        12'b1001_1001_0100, 12'b0010_0001_0000, 12'b0000_0000_0000, 12'b1000_1100_0101,
        12'b0000_0000_0111, 12'b0000_0000_0000, 12'b0100_0000_1000, 12'b1001_1101_0100,
        12'b0111_0000_0010, 12'b0011_0011_0010, 12'b0110_1100_0000, 12'b0000_0000_0011,
        12'b1000_0000_0000, 12'b0001_0100_0101, 12'b0001_0000_0000, 12'b1000_0100_0011,
        12'b0000_0000_0111, 12'b0100_0010_0101, 12'b1000_0000_1000, 12'b0111_0001_0000,
        12'b0100_0000_0010, 12'b0001_0000_0100, 12'b0000_1001_1100, 12'b1000_1000_0100,
        12'b0100_0000_1000, 12'b1010_0001_0001, 12'b0101_1001_0000, 12'b0000_1010_0000,
        12'b1000_0000_1101, 12'b0110_0001_0001, 12'b0110_0000_0100, 12'b0000_1111_0000,
        12'b0001_1100_0111, 12'b1011_0100_0001, 12'b1001_0010_0000, 12'b1000_0010_1001,
        12'b1000_1100_0010, 12'b1010_0100_0100, 12'b1000_0000_0001, 12'b0000_1000_1101
    };

    // Neuron 2 is held at 0. Neuron 5 has empty masks and so always fires.
    localparam nn_types_pkg::hidden_vec_t hidden_tie_off = 40'h00_0000_0004;

    //////////////////////////////
    // Class scorers
    //////////////////////////////

    // Neuron 0 is the leftmost bit. A negative mask bit counts a cleared neuron.
    localparam logic [0:`NN_HIDDEN_CNT-1] class_pos_mask [`NN_CLASS_CNT] = '{
        40'b0000_0010_0010_0100_0100_1000_1100_0000_0010_0000,
        40'b0000_0010_0010_1010_0010_1000_1000_0000_0010_0000,
        40'b0100_0010_0010_0000_0110_0000_1101_0000_1000_0000,
        40'b1000_1000_0000_0000_1100_0100_1000_0001_1010_0000,
        40'b0000_0100_1001_1010_0000_0000_0000_0000_1000_0000,
        40'b1001_0000_0001_0100_0100_0000_0011_0000_1000_0001
    };

    localparam logic [0:`NN_HIDDEN_CNT-1] class_neg_mask [`NN_CLASS_CNT] = '{
        40'b0000_0000_0000_0010_1000_0010_0010_1010_1000_1000,
        40'b0000_0100_0001_0000_1000_0010_0000_0101_0101_1000,
        40'b1000_0000_0000_0100_0000_0110_0010_0000_0100_0000,
        40'b0100_0000_0001_0000_0010_0000_0000_0100_0000_0010,
        40'b0000_1000_0000_0000_0010_0000_0100_0101_0001_0010,
        40'b0000_0000_0000_0000_0010_0001_0000_0100_0001_0010
    };

    localparam nn_types_pkg::score_t class_bias [`NN_CLASS_CNT] = '{
        8'd1, 8'd0, 8'd2, 8'd3, 8'd4, 8'd3
    };

endpackage

/* hw/feature_port.sv */
`timescale 1ns/1ps

module feature_port (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req,
    input  nn_types_pkg::feature_word_u features,
    input  logic                        score_valid,
    input  nn_types_pkg::class_idx_t    best_class,
    output logic                        ack,
    output nn_types_pkg::class_idx_t    prediction,
    output nn_types_pkg::feature_word_u feat_word,
    output logic                        cap_valid
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUSY = 2'd1;
    localparam logic [1:0] ST_HOLD = 2'd2;

    logic [1:0] state;
    logic       capture;

    // A new request is taken only from idle, which is reached once ack has fallen.
    assign capture = (state == ST_IDLE) && req;

    //////////////////////////////
    // Handshake FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            ack        <= 1'b0;
            prediction <= '0;
            cap_valid  <= 1'b0;
        end else begin
            cap_valid <= capture;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    // The result arrives with the registered scores.
                    if (score_valid) begin
                        prediction <= best_class;
                        ack        <= 1'b1;
                        state      <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            feat_word <= features;
        end
    end

endmodule

/* hw/hidden_layer.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

module hidden_layer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  nn_types_pkg::feature_word_u feat_word,
    input  logic                        cap_valid,
    output nn_types_pkg::hidden_vec_t   hidden_vec,
    output logic                        hid_valid
);

    import nn_weights_pkg::*;

    logic [`NN_HIDDEN_CNT-1:0] hidden_next;

    // Each neuron compares the sum of its positive lanes against its negative lanes.
    always_comb begin
        logic [`NN_SUM_BITS-1:0] pos_sum;
        logic [`NN_SUM_BITS-1:0] neg_sum;
        for (int n = 0; n < `NN_HIDDEN_CNT; n++) begin
            pos_sum = '0;
            neg_sum = '0;
            for (int f = 0; f < `NN_FEAT_CNT; f++) begin
                if (hidden_pos_mask[n][f]) begin
                    pos_sum = pos_sum + (`NN_SUM_BITS)'(feat_word.lane[f]);
                end
                if (hidden_neg_mask[n][f]) begin
                    neg_sum = neg_sum + (`NN_SUM_BITS)'(feat_word.lane[f]);
                end
            end
            hidden_next[n] = (pos_sum >= neg_sum) && !hidden_tie_off[n];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hid_valid <= 1'b0;
        end else begin
            hid_valid <= cap_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cap_valid) begin
            hidden_vec <= hidden_next;
        end
    end

endmodule

/* hw/class_scorer.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

module class_scorer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  nn_types_pkg::hidden_vec_t hidden_vec,
    input  logic                      hid_valid,
    output nn_types_pkg::score_t      scores [`NN_CLASS_CNT],
    output logic                      score_valid
);

    import nn_types_pkg::*;
    import nn_weights_pkg::*;

    score_t score_next [`NN_CLASS_CNT];

    // A class gains one point per agreeing hidden bit, set or clear.
    always_comb begin
        logic [`NN_POP_BITS-1:0] pop;
        for (int c = 0; c < `NN_CLASS_CNT; c++) begin
            pop = '0;
            for (int h = 0; h < `NN_HIDDEN_CNT; h++) begin
                if (class_pos_mask[c][h] && hidden_vec[h]) begin
                    pop = pop + 1'b1;
                end
                if (class_neg_mask[c][h] && !hidden_vec[h]) begin
                    pop = pop + 1'b1;
                end
            end
            score_next[c] = (score_t'(pop) << 1) + class_bias[c];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score_valid <= 1'b0;
        end else begin
            score_valid <= hid_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (hid_valid) begin
            scores <= score_next;
        end
    end

endmodule

/* hw/argmax.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

module argmax (
    input  nn_types_pkg::score_t     scores [`NN_CLASS_CNT],
    output nn_types_pkg::class_idx_t best_class
);

    import nn_types_pkg::*;

    //////////////////////////////
    // Linear scan
    //////////////////////////////

    // Only a strictly greater score takes over, so ties go to the lowest index.
    always_comb begin
        score_t best_score;
        best_score = scores[0];
        best_class = '0;
        for (int c = 1; c < `NN_CLASS_CNT; c++) begin
            if (scores[c] > best_score) begin
                best_score = scores[c];
                best_class = class_idx_t'(c);
            end
        end
    end

endmodule

/* hw/bnn_classifier.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

module bnn_classifier (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req,
    input  logic [`NN_FEAT_CNT*`NN_FEAT_BITS-1:0] features,
    output logic                                  ack,
    output nn_types_pkg::class_idx_t              prediction
);

    import nn_types_pkg::*;

    feature_word_u feat_in;
    feature_word_u feat_word;
    logic          cap_valid;
    hidden_vec_t   hidden_vec;
    logic          hid_valid;
    score_t        scores [`NN_CLASS_CNT];
    logic          score_valid;
    class_idx_t    best_class;

    // The port carries the flat view. The stages read the lane view.
    assign feat_in.flat = features;

    feature_port feature_port_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .features    (feat_in),
        .score_valid (score_valid),
        .best_class  (best_class),
        .ack         (ack),
        .prediction  (prediction),
        .feat_word   (feat_word),
        .cap_valid   (cap_valid)
    );

    hidden_layer hidden_layer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .feat_word  (feat_word),
        .cap_valid  (cap_valid),
        .hidden_vec (hidden_vec),
        .hid_valid  (hid_valid)
    );

    class_scorer class_scorer_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .hidden_vec  (hidden_vec),
        .hid_valid   (hid_valid),
        .scores      (scores),
        .score_valid (score_valid)
    );

    argmax argmax_inst (
        .scores     (scores),
        .best_class (best_class)
    );

endmodule

/* bench/bnn_classifier_tb.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

module bnn_classifier_tb;

    import nn_types_pkg::*;
    import nn_weights_pkg::*;

    localparam int WORD_BITS   = `NN_FEAT_CNT * `NN_FEAT_BITS;
    localparam int ACK_TIMEOUT = 20;

    logic                 clk;
    logic                 rst_n;
    logic                 req;
    logic [WORD_BITS-1:0] features;
    logic                 ack;
    class_idx_t           prediction;

    bnn_classifier bnn_classifier_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .features   (features),
        .ack        (ack),
        .prediction (prediction)
    );

    always #10 clk = ~clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Lane 0 sits in the most significant nibble of the word.
    function automatic logic [`NN_HIDDEN_CNT-1:0] model_hidden(input logic [WORD_BITS-1:0] word);
        logic [`NN_HIDDEN_CNT-1:0] hid;
        int pos_sum;
        int neg_sum;
        int lane_val;
        for (int n = 0; n < `NN_HIDDEN_CNT; n++) begin
            pos_sum = 0;
            neg_sum = 0;
            for (int f = 0; f < `NN_FEAT_CNT; f++) begin
                lane_val = int'(word[(`NN_FEAT_CNT-1-f)*`NN_FEAT_BITS +: `NN_FEAT_BITS]);
                if (hidden_pos_mask[n][f]) pos_sum += lane_val;
                if (hidden_neg_mask[n][f]) neg_sum += lane_val;
            end
            hid[n] = (pos_sum >= neg_sum) && !hidden_tie_off[n];
        end
        return hid;
    endfunction

    function automatic int model_class(input logic [WORD_BITS-1:0] word);
        logic [`NN_HIDDEN_CNT-1:0] hid;
        int pop;
        int score;
        int best_score;
        int best_idx;
        hid = model_hidden(word);
        best_score = 0;
        best_idx = 0;
        for (int c = 0; c < `NN_CLASS_CNT; c++) begin
            pop = 0;
            for (int h = 0; h < `NN_HIDDEN_CNT; h++) begin
                if (class_pos_mask[c][h] && hid[h]) pop++;
                if (class_neg_mask[c][h] && !hid[h]) pop++;
            end
            score = 2 * pop + int'(class_bias[c]);
            // Ties keep the lower class index.
            if (c == 0 || score > best_score) begin
                best_score = score;
                best_idx = c;
            end
        end
        return best_idx;
    endfunction

    //////////////////////////////
    // Checks and handshake
    //////////////////////////////

    task automatic report_failure(input string text);
        $display("%s", text);
        $display("STATUS: FAIL");
        $fatal(1, "%s", text);
    endtask

    task automatic check_eq(input longint actual, input longint expected, input string what);
        if (actual != expected) begin
            report_failure($sformatf("mismatch at %0t: %s, got %0d, expected %0d",
                                     $time, what, actual, expected));
        end
    endtask

    task automatic wait_ack_high(output int cycles);
        int count;
        count = 0;
        @(negedge clk);
        while (!ack) begin
            count++;
            if (count > ACK_TIMEOUT) report_failure("timeout while waiting for ack to rise");
            else @(negedge clk);
        end
        cycles = count;
    endtask

    task automatic wait_ack_low();
        int count;
        count = 0;
        @(negedge clk);
        while (ack) begin
            count++;
            if (count > ACK_TIMEOUT) report_failure("timeout while waiting for ack to fall");
            else @(negedge clk);
        end
    endtask

    // The second edge is the one where the DUT first samples req high.
    task automatic start_item(input logic [WORD_BITS-1:0] word, output int pred,
                              output int latency);
        @(posedge clk);
        features <= word;
        req <= 1'b1;
        @(posedge clk);
        wait_ack_high(latency);
        pred = int'(prediction);
    endtask

    task automatic end_item();
        @(posedge clk);
        req <= 1'b0;
        wait_ack_low();
    endtask

    task automatic classify_and_check(input logic [WORD_BITS-1:0] word, input string what);
        int pred;
        int latency;
        start_item(word, pred, latency);
        check_eq(pred, model_class(word), what);
        end_item();
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic after_reset();
        @(negedge clk);
        check_eq(ack, 0, "ack after reset");
        check_eq(prediction, 0, "prediction after reset");
    endtask

    task automatic zero_word_latency();
        logic [`NN_HIDDEN_CNT-1:0] hid_expect;
        int pred;
        int latency;
        // Every neuron fires on an empty input except the one tied to zero.
        hid_expect = '1;
        hid_expect[2] = 1'b0;
        start_item('0, pred, latency);
        check_eq(latency, 3, "cycles from sampled req to ack");
        check_eq(bnn_classifier_inst.hidden_vec, hid_expect, "hidden vector for zero word");
        check_eq(pred, model_class('0), "prediction for zero word");
        end_item();
    endtask

    task automatic directed_patterns();
        logic [WORD_BITS-1:0] word;
        classify_and_check({`NN_FEAT_CNT{4'hF}}, "all lanes at 15");
        classify_and_check({(`NN_FEAT_CNT/2){8'h0F}}, "alternating 0 and 15");
        classify_and_check({(`NN_FEAT_CNT/2){8'hF0}}, "alternating 15 and 0");
        for (int f = 0; f < `NN_FEAT_CNT; f++) begin
            word = WORD_BITS'(4'hF) << (`NN_FEAT_BITS * (`NN_FEAT_CNT - 1 - f));
            classify_and_check(word, $sformatf("lane %0d alone at 15", f));
            word = WORD_BITS'(4'h3) << (`NN_FEAT_BITS * (`NN_FEAT_CNT - 1 - f));
            classify_and_check(word, $sformatf("lane %0d alone at 3", f));
        end
    endtask

    task automatic random_traffic();
        logic [31:0]          r_hi;
        logic [31:0]          r_lo;
        logic [WORD_BITS-1:0] word;
        for (int i = 0; i < 200; i++) begin
            r_hi = $urandom();
            r_lo = $urandom();
            word = {r_hi[15:0], r_lo};
            classify_and_check(word, $sformatf("random word %0d", i));
        end
    endtask

    task automatic held_request();
        logic [WORD_BITS-1:0] word_a;
        logic [WORD_BITS-1:0] word_b;
        int expect_a;
        int pred;
        int latency;
        word_a = 48'h0123_4567_89AB;
        word_b = 48'hFEDC_BA98_7654;
        expect_a = model_class(word_a);
        start_item(word_a, pred, latency);
        check_eq(pred, expect_a, "first held request");
        // New features on the bus must not reach the held result.
        @(posedge clk);
        features <= word_b;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_eq(ack, 1, "ack while req held");
            check_eq(prediction, expect_a, "prediction while req held");
        end
        @(posedge clk);
        req <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_eq(ack, 0, "ack one edge after req fell");
        check_eq(prediction, expect_a, "prediction after ack fell");
        classify_and_check(word_b, "second request after ack fell");
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        req = 1'b0;
        features = '0;
        void'($urandom(2899));
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        after_reset();
        zero_word_latency();
        directed_patterns();
        random_traffic();
        held_request();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hw
hw/nn_types_pkg.sv
hw/nn_weights_pkg.sv
hw/feature_port.sv
hw/hidden_layer.sv
hw/class_scorer.sv
hw/argmax.sv
hw/bnn_classifier.sv
bench/bnn_classifier_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary -Wno-fatal
TOP       := bnn_classifier_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
